// ==== verilog/rooth_pkg.sv ====
// rooth bus package
// widths, bus structs, memory map and depths shared by the bus fabric
// and its slaves
package rooth_pkg;

    // ----------------------------------------
    // widths and depths
    // ----------------------------------------
    localparam int BUS_AW      = 32;
    localparam int BUS_DW      = 32;
    localparam int REQ_CREDITS = 4;
    localparam int REQ_PTR_W   = $clog2(REQ_CREDITS);
    localparam int RAM_WORDS   = 256;
    localparam int RAM_AW      = $clog2(RAM_WORDS);
    localparam int GPIO_PINS   = 16;

    typedef logic [BUS_AW-1:0]    bus_addr_t;
    typedef logic [BUS_DW-1:0]    bus_data_t;
    typedef logic [REQ_PTR_W-1:0] req_ptr_t;
    typedef logic [REQ_PTR_W:0]   req_cnt_t;
    typedef logic [RAM_AW-1:0]    ram_idx_t;
    typedef logic [GPIO_PINS-1:0] gpio_vec_t;
    typedef logic [3:0]           region_t;
    typedef logic [3:0]           reg_off_t;

    // ----------------------------------------
    // memory map
    // ----------------------------------------
    // region is taken from addr[31:28]
    localparam region_t  REGION_RAM   = 4'h0;
    localparam region_t  REGION_TIMER = 4'h1;
    localparam region_t  REGION_GPIO  = 4'h2;

    // register offsets from addr[3:0]
    localparam reg_off_t TIMER_CTRL   = 4'h0;
    localparam reg_off_t TIMER_VALUE  = 4'h4;
    localparam reg_off_t TIMER_CMP    = 4'h8;
    localparam reg_off_t GPIO_CTRL    = 4'h0;
    localparam reg_off_t GPIO_DATA    = 4'h4;

    // ----------------------------------------
    // bus types
    // ----------------------------------------
    typedef enum logic [1:0] {
        SEL_RAM   = 2'd0,
        SEL_TIMER = 2'd1,
        SEL_GPIO  = 2'd2,
        SEL_NONE  = 2'd3
    } slave_sel_e;

    // encoding 2'b11 is left out and behaves as off
    typedef enum logic [1:0] {
        GPIO_OFF = 2'b00,
        GPIO_OUT = 2'b01,
        GPIO_IN  = 2'b10
    } gpio_mode_e;

    typedef struct packed {
        logic      we;
        bus_addr_t addr;
        bus_data_t wdata;
    } bus_req_t;

    typedef struct packed {
        logic      err;
        bus_data_t rdata;
    } bus_rsp_t;

    typedef struct packed {
        logic       valid;
        slave_sel_e sel;
        bus_req_t   req;
    } dec_stage_t;

endpackage

// ==== verilog/bus_req_fifo.sv ====
// request FIFO
// holds the credited requests of the master and hands back one credit
// for every entry taken by the decode stage
module bus_req_fifo (
    input  logic                clk,
    input  logic                arst_n_i,
    input  logic                req_valid_i,
    input  rooth_pkg::bus_req_t req_i,
    input  logic                pop_i,
    output rooth_pkg::bus_req_t head_o,
    output logic                not_empty_o,
    output logic                credit_o
);

    rooth_pkg::bus_req_t mem [rooth_pkg::REQ_CREDITS];

    rooth_pkg::req_ptr_t wr_ptr;
    rooth_pkg::req_ptr_t rd_ptr;
    rooth_pkg::req_cnt_t count;

    // ----------------------------------------
    // storage
    // ----------------------------------------
    // master never pushes without a credit so no full check
    always_ff @(posedge clk) begin
        if (req_valid_i) begin
            mem[wr_ptr] <= req_i;
        end
    end

    assign head_o      = mem[rd_ptr];
    assign not_empty_o = (count != '0);

    // ----------------------------------------
    // pointers and count
    // ----------------------------------------
    // depth is a power of two so pointers wrap on their own
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (req_valid_i) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop_i) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({req_valid_i, pop_i})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // one credit back per pop, a cycle later
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            credit_o <= 1'b0;
        end else begin
            credit_o <= pop_i;
        end
    end

endmodule

// ==== verilog/bus_addr_decode.sv ====
// address decode stage
// takes the FIFO head while the bus is free, tags it with the target
// slave and registers the tagged request for the slave stage
module bus_addr_decode (
    input  logic                  clk,
    input  logic                  arst_n_i,
    input  logic                  hold_i,
    input  rooth_pkg::bus_req_t   head_i,
    input  logic                  not_empty_i,
    output logic                  pop_o,
    output rooth_pkg::dec_stage_t dec_o
);

    rooth_pkg::slave_sel_e sel_d;
    rooth_pkg::slave_sel_e sel_q;
    rooth_pkg::bus_req_t   req_q;
    logic                  valid_q;

    // nothing moves while another master owns the bus
    assign pop_o = not_empty_i && !hold_i;

    // region lookup on the top nibble
    always_comb begin
        case (head_i.addr[31:28])
            rooth_pkg::REGION_RAM:   sel_d = rooth_pkg::SEL_RAM;
            rooth_pkg::REGION_TIMER: sel_d = rooth_pkg::SEL_TIMER;
            rooth_pkg::REGION_GPIO:  sel_d = rooth_pkg::SEL_GPIO;
            default:                 sel_d = rooth_pkg::SEL_NONE;
        endcase
    end

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= pop_o;
        end
    end

    always_ff @(posedge clk) begin
        if (pop_o) begin
            sel_q <= sel_d;
            req_q <= head_i;
        end
    end

    assign dec_o = '{valid: valid_q, sel: sel_q, req: req_q};

endmodule

// ==== verilog/data_ram.sv ====
// data RAM slave
// word addressed synchronous RAM, read data registered one cycle
// after the select
module data_ram (
    input  logic                  clk,
    input  rooth_pkg::dec_stage_t dec_i,
    output rooth_pkg::bus_data_t  rdata_o
);

    rooth_pkg::bus_data_t mem [rooth_pkg::RAM_WORDS];

    rooth_pkg::ram_idx_t idx;
    logic                hit;

    // byte address to word index
    assign idx = dec_i.req.addr[2 +: rooth_pkg::RAM_AW];
    assign hit = dec_i.valid && (dec_i.sel == rooth_pkg::SEL_RAM);

    always_ff @(posedge clk) begin
        if (hit && dec_i.req.we) begin
            mem[idx] <= dec_i.req.wdata;
        end
    end

    always_ff @(posedge clk) begin
        if (hit && !dec_i.req.we) begin
            rdata_o <= mem[idx];
        end
    end

endmodule

// ==== verilog/timer.sv ====
// timer slave
// free running counter with compare match, sticky pending flag and
// a registered interrupt
module timer (
    input  logic                  clk,
    input  logic                  arst_n_i,
    input  rooth_pkg::dec_stage_t dec_i,
    output rooth_pkg::bus_data_t  rdata_o,
    output logic                  irq_o
);

    rooth_pkg::bus_data_t value_q;
    rooth_pkg::bus_data_t cmp_q;
    rooth_pkg::reg_off_t  off;

    logic enable_q;
    logic pending_q;
    logic irq_en_q;
    logic hit;
    logic wr;
    logic match;

    assign off   = dec_i.req.addr[3:0];
    assign hit   = dec_i.valid && (dec_i.sel == rooth_pkg::SEL_TIMER);
    assign wr    = hit && dec_i.req.we;
    assign match = enable_q && (value_q == cmp_q);

    // ----------------------------------------
    // control and compare registers
    // ----------------------------------------
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            enable_q <= 1'b0;
            irq_en_q <= 1'b0;
            cmp_q    <= '0;
        end else if (wr) begin
            if (off == rooth_pkg::TIMER_CTRL) begin
                enable_q <= dec_i.req.wdata[0];
                irq_en_q <= dec_i.req.wdata[2];
            end
            if (off == rooth_pkg::TIMER_CMP) begin
                cmp_q <= dec_i.req.wdata;
            end
        end
    end

    // a match in the same cycle as a clear keeps the flag set
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            pending_q <= 1'b0;
        end else if (match) begin
            pending_q <= 1'b1;
        end else if (wr && off == rooth_pkg::TIMER_CTRL && dec_i.req.wdata[1]) begin
            pending_q <= 1'b0;
        end
    end

    // ----------------------------------------
    // counter
    // ----------------------------------------
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            value_q <= '0;
        end else if (wr && off == rooth_pkg::TIMER_VALUE) begin
            value_q <= dec_i.req.wdata;
        end else if (match) begin
            value_q <= '0;
        end else if (enable_q) begin
            value_q <= value_q + 1'b1;
        end
    end

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            irq_o <= 1'b0;
        end else begin
            irq_o <= pending_q && irq_en_q;
        end
    end

    // register read port
    always_ff @(posedge clk) begin
        if (hit && !dec_i.req.we) begin
            case (off)
                rooth_pkg::TIMER_CTRL:  rdata_o <= {29'd0, irq_en_q, pending_q, enable_q};
                rooth_pkg::TIMER_VALUE: rdata_o <= value_q;
                rooth_pkg::TIMER_CMP:   rdata_o <= cmp_q;
                default:                rdata_o <= '0;
            endcase
        end
    end

endmodule

// ==== verilog/gpio.sv ====
// GPIO slave
// per pin 2-bit mode, output data register and double flopped input
// sampling for pins in input mode
module gpio (
    input  logic                  clk,
    input  logic                  arst_n_i,
    input  rooth_pkg::dec_stage_t dec_i,
    output rooth_pkg::bus_data_t  rdata_o,
    input  rooth_pkg::gpio_vec_t  pin_in_i,
    output rooth_pkg::gpio_vec_t  pin_out_o,
    output rooth_pkg::gpio_vec_t  pin_oe_o
);

    rooth_pkg::gpio_mode_e [rooth_pkg::GPIO_PINS-1:0] mode_q;

    rooth_pkg::gpio_vec_t data_q;
    rooth_pkg::gpio_vec_t sync1_q;
    rooth_pkg::gpio_vec_t sync2_q;
    rooth_pkg::gpio_vec_t rd_pins;
    rooth_pkg::reg_off_t  off;
    logic                 hit;

    assign off = dec_i.req.addr[3:0];
    assign hit = dec_i.valid && (dec_i.sel == rooth_pkg::SEL_GPIO);

    // ----------------------------------------
    // mode and data registers
    // ----------------------------------------
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            for (int i = 0; i < rooth_pkg::GPIO_PINS; i++) begin
                mode_q[i] <= rooth_pkg::GPIO_OFF;
            end
            data_q <= '0;
        end else if (hit && dec_i.req.we) begin
            if (off == rooth_pkg::GPIO_CTRL) begin
                for (int i = 0; i < rooth_pkg::GPIO_PINS; i++) begin
                    mode_q[i] <= rooth_pkg::gpio_mode_e'(dec_i.req.wdata[2*i +: 2]);
                end
            end
            if (off == rooth_pkg::GPIO_DATA) begin
                data_q <= dec_i.req.wdata[rooth_pkg::GPIO_PINS-1:0];
            end
        end
    end

    // two flop synchronizer on the pad inputs
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            sync1_q <= '0;
            sync2_q <= '0;
        end else begin
            sync1_q <= pin_in_i;
            sync2_q <= sync1_q;
        end
    end

    // input pins read the pad, the rest read back DATA
    always_comb begin
        for (int i = 0; i < rooth_pkg::GPIO_PINS; i++) begin
            pin_oe_o[i] = (mode_q[i] == rooth_pkg::GPIO_OUT);
            rd_pins[i]  = (mode_q[i] == rooth_pkg::GPIO_IN) ? sync2_q[i] : data_q[i];
        end
    end

    assign pin_out_o = data_q;

    always_ff @(posedge clk) begin
        if (hit && !dec_i.req.we) begin
            case (off)
                rooth_pkg::GPIO_CTRL: rdata_o <= rooth_pkg::bus_data_t'(mode_q);
                rooth_pkg::GPIO_DATA: rdata_o <= rooth_pkg::bus_data_t'(rd_pins);
                default:              rdata_o <= '0;
            endcase
        end
    end

endmodule

// ==== verilog/bus_resp_stage.sv ====
// response stage
// lines the request tag up with the slave read data and registers
// the response to the master
module bus_resp_stage (
    input  logic                  clk,
    input  logic                  arst_n_i,
    input  rooth_pkg::dec_stage_t dec_i,
    input  rooth_pkg::bus_data_t  ram_rdata_i,
    input  rooth_pkg::bus_data_t  tmr_rdata_i,
    input  rooth_pkg::bus_data_t  gpio_rdata_i,
    output logic                  rsp_valid_o,
    output rooth_pkg::bus_rsp_t   rsp_o
);

    rooth_pkg::slave_sel_e sel_q;
    rooth_pkg::bus_rsp_t   rsp_d;
    logic                  valid_q;
    logic                  we_q;

    // tag copy, same edge as the slave access
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= dec_i.valid;
        end
    end

    always_ff @(posedge clk) begin
        sel_q <= dec_i.sel;
        we_q  <= dec_i.req.we;
    end

    // read data mux, writes and unmapped return zero
    always_comb begin
        rsp_d.err = (sel_q == rooth_pkg::SEL_NONE);
        case (sel_q)
            rooth_pkg::SEL_RAM:   rsp_d.rdata = ram_rdata_i;
            rooth_pkg::SEL_TIMER: rsp_d.rdata = tmr_rdata_i;
            rooth_pkg::SEL_GPIO:  rsp_d.rdata = gpio_rdata_i;
            default:              rsp_d.rdata = '0;
        endcase
        if (we_q) begin
            rsp_d.rdata = '0;
        end
    end

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            rsp_valid_o <= 1'b0;
        end else begin
            rsp_valid_o <= valid_q;
        end
    end

    always_ff @(posedge clk) begin
        rsp_o <= rsp_d;
    end

endmodule

// ==== verilog/rooth_soc.sv ====
// rooth SoC bus side
// credited request FIFO, decode, slave and response stages with the
// data RAM, timer and GPIO slaves behind an external master port
module rooth_soc (
    input  logic                clk,
    input  logic                arst_n_i,
    input  logic                req_valid_i,
    input  rooth_pkg::bus_req_t req_i,
    output logic                credit_o,
    input  logic                hold_i,
    output logic                rsp_valid_o,
    output rooth_pkg::bus_rsp_t rsp_o,
    output logic                irq_o,
    inout  wire [rooth_pkg::GPIO_PINS-1:0] gpio_io
);

    rooth_pkg::bus_req_t   head;
    rooth_pkg::dec_stage_t dec;
    rooth_pkg::bus_data_t  ram_rdata;
    rooth_pkg::bus_data_t  tmr_rdata;
    rooth_pkg::bus_data_t  gpio_rdata;
    rooth_pkg::gpio_vec_t  pin_in;
    rooth_pkg::gpio_vec_t  pin_out;
    rooth_pkg::gpio_vec_t  pin_oe;
    logic                  not_empty;
    logic                  pop;

    // ----------------------------------------
    // request path
    // ----------------------------------------
    bus_req_fifo u_bus_req_fifo (
        .clk         (clk),
        .arst_n_i    (arst_n_i),
        .req_valid_i (req_valid_i),
        .req_i       (req_i),
        .pop_i       (pop),
        .head_o      (head),
        .not_empty_o (not_empty),
        .credit_o    (credit_o)
    );

    bus_addr_decode u_bus_addr_decode (
        .clk         (clk),
        .arst_n_i    (arst_n_i),
        .hold_i      (hold_i),
        .head_i      (head),
        .not_empty_i (not_empty),
        .pop_o       (pop),
        .dec_o       (dec)
    );

    // ----------------------------------------
    // slaves
    // ----------------------------------------
    data_ram u_data_ram (
        .clk     (clk),
        .dec_i   (dec),
        .rdata_o (ram_rdata)
    );

    timer u_timer (
        .clk      (clk),
        .arst_n_i (arst_n_i),
        .dec_i    (dec),
        .rdata_o  (tmr_rdata),
        .irq_o    (irq_o)
    );

    gpio u_gpio (
        .clk       (clk),
        .arst_n_i  (arst_n_i),
        .dec_i     (dec),
        .rdata_o   (gpio_rdata),
        .pin_in_i  (pin_in),
        .pin_out_o (pin_out),
        .pin_oe_o  (pin_oe)
    );

    // pad tristates, pins float unless in output mode
    for (genvar i = 0; i < rooth_pkg::GPIO_PINS; i++) begin : g_pad
        assign gpio_io[i] = pin_oe[i] ? pin_out[i] : 1'bz;
    end
    assign pin_in = gpio_io;

    // ----------------------------------------
    // response path
    // ----------------------------------------
    bus_resp_stage u_bus_resp_stage (
        .clk          (clk),
        .arst_n_i     (arst_n_i),
        .dec_i        (dec),
        .ram_rdata_i  (ram_rdata),
        .tmr_rdata_i  (tmr_rdata),
        .gpio_rdata_i (gpio_rdata),
        .rsp_valid_o  (rsp_valid_o),
        .rsp_o        (rsp_o)
    );

endmodule

// ==== tests/tb_clk_gen.sv ====
// testbench clock and reset
// 20 ns clock, active low reset held for the first 10 cycles
module tb_clk_gen (
    output logic clk_o,
    output logic arst_n_o
);
    timeunit 1ns;
    timeprecision 1ps;

    localparam int HALF_PERIOD  = 10;
    localparam int RESET_CYCLES = 10;

    initial begin
        clk_o = 1'b0;
        forever begin
            #(HALF_PERIOD) clk_o = ~clk_o;
        end
    end

    // release away from the rising edge
    initial begin
        arst_n_o = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk_o);
        @(negedge clk_o);
        arst_n_o = 1'b1;
    end

endmodule

// ==== tests/tb_rooth_soc.sv ====
// testbench for the rooth SoC bus side
// a credited master drives RAM, timer and GPIO traffic, a model of the
// memory map predicts every response and a monitor checks them in order
module tb_rooth_soc;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int N_RAM        = 64;
    localparam int N_BURSTS     = 3;
    localparam int HOLD_CYCLES  = 10;
    localparam int PIPE_LAT     = 3;
    localparam int IRQ_WAIT     = 100;
    localparam int IRQ_LOW_WAIT = 40;
    localparam int TOTAL_REQS   = 2 * N_RAM + (N_BURSTS + 1) * rooth_pkg::REQ_CREDITS + 3 + 4 + 7;
    localparam int MAX_CYCLES   = TOTAL_REQS * 8 + IRQ_WAIT + IRQ_LOW_WAIT + 200;

    logic                           clk;
    logic                           arst_n;
    logic                           req_valid;
    rooth_pkg::bus_req_t            req;
    logic                           credit;
    logic                           hold;
    logic                           rsp_valid;
    rooth_pkg::bus_rsp_t            rsp;
    logic                           irq;
    wire [rooth_pkg::GPIO_PINS-1:0] gpio_pads;
    rooth_pkg::gpio_vec_t           pad_val;
    rooth_pkg::gpio_vec_t           pad_en;

    integer                         seed;
    int                             credits;
    int                             cycles = 0;
    rooth_pkg::bus_rsp_t            exp_q[$];
    string                          name_q[$];
    rooth_pkg::bus_addr_t           ram_addrs [N_RAM];

    // model state of the slaves
    rooth_pkg::bus_data_t           ram_model [rooth_pkg::RAM_WORDS];
    logic [1:0]                     mode_model [rooth_pkg::GPIO_PINS];
    rooth_pkg::gpio_vec_t           data_model;
    rooth_pkg::bus_data_t           cmp_model;
    logic                           tmr_en_model;
    logic                           tmr_irq_en_model;
    logic                           tmr_pending_model;

    tb_clk_gen u_clk_gen (
        .clk_o    (clk),
        .arst_n_o (arst_n)
    );

    rooth_soc u_rooth_soc (
        .clk         (clk),
        .arst_n_i    (arst_n),
        .req_valid_i (req_valid),
        .req_i       (req),
        .credit_o    (credit),
        .hold_i      (hold),
        .rsp_valid_o (rsp_valid),
        .rsp_o       (rsp),
        .irq_o       (irq),
        .gpio_io     (gpio_pads)
    );

    // external pad drivers
    for (genvar i = 0; i < rooth_pkg::GPIO_PINS; i++) begin : g_pad_drv
        assign gpio_pads[i] = pad_en[i] ? pad_val[i] : 1'bz;
    end

    // ----------------------------------------
    // failure reporting and compare tasks
    // ----------------------------------------
    task automatic abort_run();
        $display("Finished with errors");
        $fatal(1, "stopping at the first failed check");
    endtask

    task automatic check_rsp(input string name, input rooth_pkg::bus_rsp_t exp,
                             input rooth_pkg::bus_rsp_t act);
        if (act !== exp) begin
            $display("[ERROR] %s: expected err=%0b rdata=%h, actual err=%0b rdata=%h",
                     name, exp.err, exp.rdata, act.err, act.rdata);
            abort_run();
        end
    endtask

    task automatic check_data(input string name, input rooth_pkg::bus_data_t exp,
                              input rooth_pkg::bus_data_t act);
        if (act !== exp) begin
            $display("[ERROR] %s: expected %h, actual %h", name, exp, act);
            abort_run();
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("[ERROR] %s: expected %b, actual %b", name, exp, act);
            abort_run();
        end
    endtask

    // ----------------------------------------
    // memory map model
    // ----------------------------------------
    function automatic rooth_pkg::bus_rsp_t expected_rsp(input rooth_pkg::bus_req_t r);
        rooth_pkg::bus_rsp_t rsp_e;
        rooth_pkg::reg_off_t off;
        int                  idx;

        rsp_e = '0;
        off   = r.addr[3:0];
        idx   = int'(r.addr[9:2]);
        case (r.addr[31:28])
            rooth_pkg::REGION_RAM: begin
                if (r.we) begin
                    ram_model[idx] = r.wdata;
                end else begin
                    rsp_e.rdata = ram_model[idx];
                end
            end
            // VALUE runs freely and is never read
            rooth_pkg::REGION_TIMER: begin
                if (r.we && off == rooth_pkg::TIMER_CTRL) begin
                    tmr_en_model     = r.wdata[0];
                    tmr_irq_en_model = r.wdata[2];
                    if (r.wdata[1]) begin
                        tmr_pending_model = 1'b0;
                    end
                end else if (r.we && off == rooth_pkg::TIMER_CMP) begin
                    cmp_model = r.wdata;
                end else if (!r.we && off == rooth_pkg::TIMER_CTRL) begin
                    rsp_e.rdata = {29'd0, tmr_irq_en_model, tmr_pending_model, tmr_en_model};
                end else if (!r.we && off == rooth_pkg::TIMER_CMP) begin
                    rsp_e.rdata = cmp_model;
                end
            end
            rooth_pkg::REGION_GPIO: begin
                if (r.we && off == rooth_pkg::GPIO_DATA) begin
                    data_model = r.wdata[rooth_pkg::GPIO_PINS-1:0];
                end
                for (int i = 0; i < rooth_pkg::GPIO_PINS; i++) begin
                    if (r.we && off == rooth_pkg::GPIO_CTRL) begin
                        mode_model[i] = r.wdata[2*i +: 2];
                    end else if (!r.we && off == rooth_pkg::GPIO_CTRL) begin
                        rsp_e.rdata[2*i +: 2] = mode_model[i];
                    end else if (!r.we && off == rooth_pkg::GPIO_DATA) begin
                        // input pins see the pad, the others read back DATA
                        if (mode_model[i] == rooth_pkg::GPIO_IN) begin
                            rsp_e.rdata[i] = pad_en[i] ? pad_val[i] : 1'bx;
                        end else begin
                            rsp_e.rdata[i] = data_model[i];
                        end
                    end
                end
            end
            default: rsp_e.err = 1'b1;
        endcase
        return rsp_e;
    endfunction

    function automatic rooth_pkg::bus_req_t bus_request(input logic we,
                                                        input rooth_pkg::bus_addr_t addr,
                                                        input rooth_pkg::bus_data_t wdata);
        rooth_pkg::bus_req_t r;

        r.we    = we;
        r.addr  = addr;
        r.wdata = wdata;
        return r;
    endfunction

    function automatic rooth_pkg::bus_addr_t reg_addr(input rooth_pkg::region_t region,
                                                      input rooth_pkg::reg_off_t off);
        return {region, 24'd0, off};
    endfunction

    // ----------------------------------------
    // master side
    // ----------------------------------------
    // spent on each pushed request, regained on each credit pulse
    always @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            credits = rooth_pkg::REQ_CREDITS;
        end else begin
            credits = credits + int'(credit) - int'(req_valid);
            if (credits < 0 || credits > rooth_pkg::REQ_CREDITS) begin
                $display("[ERROR] credit count left its range, now %0d", credits);
                abort_run();
            end
        end
    end

    task automatic send_req(input string name, input rooth_pkg::bus_req_t r);
        @(negedge clk);
        while (credits == 0) begin
            req_valid = 1'b0;
            @(negedge clk);
        end
        req_valid = 1'b1;
        req       = r;
        exp_q.push_back(expected_rsp(r));
        name_q.push_back(name);
    endtask

    task automatic idle_cycle();
        @(negedge clk);
        req_valid = 1'b0;
    endtask

    // wait for all responses and all credits
    task automatic drain_bus();
        logic busy;

        idle_cycle();
        busy = 1'b1;
        while (busy) begin
            @(posedge clk);
            busy = (exp_q.size() != 0);
            @(negedge clk);
            busy = busy || (credits != rooth_pkg::REQ_CREDITS);
        end
    endtask

    task automatic wait_irq(input logic level, input int max_cycles, input string what);
        int n;

        n = 0;
        idle_cycle();
        while (irq !== level) begin
            if (n == max_cycles) begin
                $display("[ERROR] %s", what);
                abort_run();
            end
            n++;
            idle_cycle();
        end
    endtask

    // response monitor
    always @(negedge clk) begin
        if (arst_n && rsp_valid === 1'b1) begin
            if (exp_q.size() == 0) begin
                $display("[ERROR] a response arrived with no request outstanding");
                abort_run();
            end else begin
                check_rsp(name_q.pop_front(), exp_q.pop_front(), rsp);
            end
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles > MAX_CYCLES) begin
            $display("[ERROR] no progress after %0d cycles, the bus stopped responding",
                     MAX_CYCLES);
            abort_run();
        end
    end

    // ----------------------------------------
    // tests
    // ----------------------------------------
    task automatic after_reset();
        check_bit("reset rsp_valid", 1'b0, rsp_valid);
        check_bit("reset credit", 1'b0, credit);
        check_bit("reset irq", 1'b0, irq);
        for (int i = 0; i < rooth_pkg::GPIO_PINS; i++) begin
            check_bit("pad in off mode", 1'bz, gpio_pads[i]);
        end
    endtask

    task automatic ram_fill_and_readback();
        rooth_pkg::ram_idx_t idx;

        for (int i = 0; i < N_RAM; i++) begin
            idx          = rooth_pkg::ram_idx_t'($random(seed));
            ram_addrs[i] = rooth_pkg::bus_addr_t'({idx, 2'b00});
            send_req("ram write", bus_request(1'b1, ram_addrs[i], $random(seed)));
        end
        for (int i = 0; i < N_RAM; i++) begin
            send_req("ram read", bus_request(1'b0, ram_addrs[i], '0));
        end
        drain_bus();
    endtask

    task automatic credit_bursts();
        rooth_pkg::bus_addr_t addr;

        for (int b = 0; b < N_BURSTS; b++) begin
            for (int k = 0; k < rooth_pkg::REQ_CREDITS; k++) begin
                addr = ram_addrs[$unsigned($random(seed)) % N_RAM];
                send_req("credit burst", bus_request((k % 2) == 0, addr, $random(seed)));
            end
        end
        drain_bus();
    endtask

    task automatic hold_bus();
        hold = 1'b1;
        for (int k = 0; k < rooth_pkg::REQ_CREDITS; k++) begin
            send_req("held request", bus_request((k % 2) == 0, ram_addrs[k / 2], $random(seed)));
        end
        idle_cycle();
        repeat (HOLD_CYCLES) begin
            check_bit("rsp_valid while held", 1'b0, rsp_valid);
            check_bit("credit while held", 1'b0, credit);
            idle_cycle();
        end
        hold = 1'b0;
        drain_bus();
    endtask

    task automatic unmapped_access();
        rooth_pkg::bus_addr_t addr;

        // region 3 with the RAM offset of an earlier write
        addr = {4'h3, ram_addrs[0][27:0]};
        send_req("unmapped write", bus_request(1'b1, addr, $random(seed)));
        send_req("unmapped read", bus_request(1'b0, addr, '0));
        send_req("ram after unmapped", bus_request(1'b0, ram_addrs[0], '0));
        drain_bus();
    endtask

    task automatic gpio_pins();
        rooth_pkg::bus_data_t ctrl_word;
        rooth_pkg::gpio_vec_t data;

        ctrl_word = '0;
        for (int i = 0; i < rooth_pkg::GPIO_PINS; i++) begin
            ctrl_word[2*i +: 2] = (i < 8) ? rooth_pkg::GPIO_OUT : rooth_pkg::GPIO_IN;
        end
        data = rooth_pkg::gpio_vec_t'($random(seed));
        send_req("gpio ctrl write", bus_request(1'b1,
                 reg_addr(rooth_pkg::REGION_GPIO, rooth_pkg::GPIO_CTRL), ctrl_word));
        send_req("gpio data write", bus_request(1'b1,
                 reg_addr(rooth_pkg::REGION_GPIO, rooth_pkg::GPIO_DATA), 32'(data)));
        drain_bus();
        check_data("gpio output pins", 32'(data[7:0]), 32'(gpio_pads[7:0]));

        // drive the upper half and let the synchronizer settle
        pad_val[15:8] = 8'($random(seed));
        pad_en[15:8]  = 8'hff;
        repeat (4) idle_cycle();
        send_req("gpio data read", bus_request(1'b0,
                 reg_addr(rooth_pkg::REGION_GPIO, rooth_pkg::GPIO_DATA), '0));
        send_req("gpio ctrl read", bus_request(1'b0,
                 reg_addr(rooth_pkg::REGION_GPIO, rooth_pkg::GPIO_CTRL), '0));
        drain_bus();
    endtask

    task automatic timer_irq();
        rooth_pkg::bus_addr_t ctrl;
        rooth_pkg::bus_addr_t cmp;

        ctrl = reg_addr(rooth_pkg::REGION_TIMER, rooth_pkg::TIMER_CTRL);
        cmp  = reg_addr(rooth_pkg::REGION_TIMER, rooth_pkg::TIMER_CMP);
        send_req("timer cmp write", bus_request(1'b1, cmp, 32'd20));
        send_req("timer cmp read", bus_request(1'b0, cmp, '0));
        send_req("timer enable", bus_request(1'b1, ctrl, 32'h5));
        wait_irq(1'b1, IRQ_WAIT, "timer interrupt did not rise within 100 cycles");
        // the compare match sets pending
        tmr_pending_model = 1'b1;
        send_req("timer pending read", bus_request(1'b0, ctrl, '0));
        send_req("timer disable", bus_request(1'b1, ctrl, 32'h4));
        drain_bus();
        check_bit("irq while pending", 1'b1, irq);
        send_req("timer pending clear", bus_request(1'b1, ctrl, 32'h6));
        wait_irq(1'b0, PIPE_LAT, "timer interrupt stayed high after the pending clear");
        repeat (IRQ_LOW_WAIT) begin
            idle_cycle();
            check_bit("irq with timer disabled", 1'b0, irq);
        end
        send_req("timer ctrl read", bus_request(1'b0, ctrl, '0));
        drain_bus();
    endtask

    // ----------------------------------------
    // main sequence
    // ----------------------------------------
    initial begin
        seed              = 32'h6d4b_4dcb;
        req_valid         = 1'b0;
        req               = '0;
        hold              = 1'b0;
        pad_val           = '0;
        pad_en            = '0;
        data_model        = '0;
        cmp_model         = '0;
        tmr_en_model      = 1'b0;
        tmr_irq_en_model  = 1'b0;
        tmr_pending_model = 1'b0;
        for (int i = 0; i < rooth_pkg::GPIO_PINS; i++) begin
            mode_model[i] = rooth_pkg::GPIO_OFF;
        end

        @(posedge arst_n);
        after_reset();
        ram_fill_and_readback();
        credit_bursts();
        hold_bus();
        unmapped_access();
        gpio_pins();
        timer_irq();
        idle_cycle();

        $display("Finished with no errors");
        $finish;
    end

endmodule

// ==== verilog.f ====
verilog/rooth_pkg.sv
verilog/bus_req_fifo.sv
verilog/bus_addr_decode.sv
verilog/data_ram.sv
verilog/timer.sv
verilog/gpio.sv
verilog/bus_resp_stage.sv
verilog/rooth_soc.sv
tests/tb_clk_gen.sv
tests/tb_rooth_soc.sv
